/* eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // 24C16 style part, 2 KiB behind one device code
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // one scl period is four quarters
    localparam int SCL_QUARTER = 4;  // clk cycles per quarter
    localparam int QCNT_W = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1;

    // five commands do not fit in two bits
    typedef enum logic [2:0] {
        CMD_START,
        CMD_WRITE,
        CMD_READ_ACK,
        CMD_READ_NACK,
        CMD_STOP
    } bit_cmd_e;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_WR,
        S_ADDR,
        S_DATA_WR,
        S_RESTART,  // repeated start before the read control byte
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP,
        S_RESP
    } seq_state_e;

    typedef enum logic [2:0] {
        B_IDLE,
        B_START,
        B_SHIFT,
        B_ACK,  // ninth bit of a byte
        B_STOP
    } bit_state_e;

endpackage

`default_nettype wire

/* i2c_bit_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET,
    input  wire logic              cmd_valid,
    input  wire bit_cmd_e          cmd_op,
    input  wire logic [DATA_W-1:0] cmd_byte,
    input  wire logic              sda_in,
    output logic                   cmd_ready,
    output logic                   done,
    output logic [DATA_W-1:0]      rx_byte,
    output logic                   ack_seen,
    output logic                   scl,
    output logic                   sda_drive_low
);

    bit_state_e        state;
    bit_cmd_e          op;
    logic [QCNT_W-1:0] qcnt;
    logic [1:0]        quarter;
    logic [2:0]        bitcnt;
    logic [DATA_W-1:0] shreg;
    logic [1:0]        sda_sync;
    logic              accept;
    logic              tick;
    logic              finish;

    assign accept = cmd_valid && cmd_ready;
    assign tick   = (state != B_IDLE) && (qcnt == QCNT_W'(SCL_QUARTER - 1));

    // start, stop and ack end the command, a data bit never does
    assign finish = tick && (quarter == 2'd3) && (state != B_SHIFT);

    // each command opens with scl low, then quarters go low/high/high/low
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= B_IDLE;
            qcnt          <= '0;
            quarter       <= '0;
            bitcnt        <= '0;
            scl           <= 1'b1;  // bus idle
            sda_drive_low <= 1'b0;
            cmd_ready     <= 1'b1;
            done          <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (state == B_IDLE)
            begin
                qcnt    <= '0;
                quarter <= '0;
                bitcnt  <= '0;
                if (accept)
                begin
                    cmd_ready <= 1'b0;
                    scl       <= 1'b0;
                    case (cmd_op)
                        CMD_START:
                        begin
                            state         <= B_START;
                            sda_drive_low <= 1'b0;  // release before scl rises
                        end
                        CMD_STOP:
                        begin
                            state         <= B_STOP;
                            sda_drive_low <= 1'b1;
                        end
                        CMD_WRITE:
                        begin
                            state         <= B_SHIFT;
                            sda_drive_low <= ~cmd_byte[DATA_W-1];  // msb first
                        end
                        default:
                        begin
                            state         <= B_SHIFT;
                            sda_drive_low <= 1'b0;  // slave drives
                        end
                    endcase
                end
            end
            else
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                begin
                    quarter <= quarter + 1'b1;
                    case (quarter)
                        2'd0: scl <= 1'b1;
                        2'd1:
                        begin
                            // sda moves while scl is high only here
                            if (state == B_START)
                                sda_drive_low <= 1'b1;
                            else if (state == B_STOP)
                                sda_drive_low <= 1'b0;
                        end
                        2'd2:
                        begin
                            if (state != B_STOP)
                                scl <= 1'b0;
                        end
                        default:
                        begin
                            if (state == B_SHIFT)
                            begin
                                if (bitcnt == 3'd7)
                                begin
                                    state         <= B_ACK;
                                    sda_drive_low <= (op == CMD_READ_ACK);
                                end
                                else
                                begin
                                    bitcnt        <= bitcnt + 1'b1;
                                    sda_drive_low <= (op == CMD_WRITE) && !shreg[DATA_W-1];
                                end
                            end
                            else
                            begin
                                state     <= B_IDLE;
                                done      <= 1'b1;
                                cmd_ready <= 1'b1;
                            end
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        sda_sync <= {sda_sync[0], sda_in};
        if (accept)
        begin
            op    <= cmd_op;
            shreg <= cmd_byte;
        end
        if (tick && quarter == 2'd1)  // middle of the high phase
        begin
            if (state == B_SHIFT)
                shreg <= {shreg[DATA_W-2:0], sda_sync[1]};
            if (state == B_ACK)
                ack_seen <= ~sda_sync[1];
        end
        if (finish && state == B_ACK)
            rx_byte <= shreg;
    end

    // only start and stop may move sda under a high scl
    a_sda_only_low_scl: assert property (@(posedge CLK) disable iff (RESET)
        (state != B_START && state != B_STOP && $changed(sda_drive_low)) |-> !scl);

    a_ready_only_idle: assert property (@(posedge CLK) disable iff (RESET)
        (state != B_IDLE) |-> !cmd_ready);

endmodule

`default_nettype wire

/* eeprom_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET,
    input  wire logic              req_valid,
    input  wire logic              req_write,
    input  wire logic [ADDR_W-1:0] req_addr,
    input  wire logic [DATA_W-1:0] req_wdata,
    output logic                   req_ready,
    output logic                   rsp_valid,
    input  wire logic              rsp_ready,
    output logic [DATA_W-1:0]      rsp_rdata,
    output logic                   rsp_nack,
    output logic                   cmd_valid,
    output bit_cmd_e               cmd_op,
    output logic [DATA_W-1:0]      cmd_byte,
    input  wire logic              cmd_ready,
    input  wire logic              done,
    input  wire logic [DATA_W-1:0] rx_byte,
    input  wire logic              ack_seen
);

    seq_state_e        state;
    seq_state_e        state_n;
    logic [ADDR_W-1:0] addr_r;
    logic [DATA_W-1:0] wdata_r;
    logic              write_r;
    logic              launch;
    logic              byte_state;

    function automatic bit_cmd_e op_for(input seq_state_e s);
        case (s)
            S_START, S_RESTART: return CMD_START;
            S_DATA_RD:          return CMD_READ_NACK;  // single byte, master nacks
            S_STOP:             return CMD_STOP;
            default:            return CMD_WRITE;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] byte_for(
        input seq_state_e        s,
        input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] wdata
    );
        case (s)
            S_CTRL_WR: return {DEV_CODE, addr[ADDR_W-1:DATA_W], 1'b0};
            S_CTRL_RD: return {DEV_CODE, addr[ADDR_W-1:DATA_W], 1'b1};
            S_ADDR:    return addr[DATA_W-1:0];
            S_DATA_WR: return wdata;
            default:   return '0;
        endcase
    endfunction

    assign req_ready  = (state == S_IDLE);
    assign byte_state = (state == S_CTRL_WR) || (state == S_ADDR) ||
                        (state == S_DATA_WR) || (state == S_CTRL_RD);

    // a new bus step starts on every entry into a bus state
    assign launch = (state_n != state) && (state_n != S_IDLE) && (state_n != S_RESP);

    always_comb
    begin
        state_n = state;
        case (state)
            S_IDLE:    if (req_valid) state_n = S_START;
            S_START:   if (done) state_n = S_CTRL_WR;
            S_CTRL_WR: if (done) state_n = ack_seen ? S_ADDR : S_STOP;
            S_ADDR:
            begin
                if (done)
                begin
                    if (!ack_seen)
                        state_n = S_STOP;
                    else
                        state_n = write_r ? S_DATA_WR : S_RESTART;
                end
            end
            S_DATA_WR: if (done) state_n = S_STOP;
            S_RESTART: if (done) state_n = S_CTRL_RD;
            S_CTRL_RD: if (done) state_n = ack_seen ? S_DATA_RD : S_STOP;
            S_DATA_RD: if (done) state_n = S_STOP;
            S_STOP:    if (done) state_n = S_RESP;
            S_RESP:    if (rsp_ready) state_n = S_IDLE;
            default:   state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            rsp_valid <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            state     <= state_n;
            rsp_valid <= (state_n == S_RESP);
            if (launch)
                cmd_valid <= 1'b1;
            else if (cmd_ready)
                cmd_valid <= 1'b0;  // taken by the engine
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            addr_r    <= req_addr;
            wdata_r   <= req_wdata;
            write_r   <= req_write;
            rsp_nack  <= 1'b0;
            rsp_rdata <= '0;
        end
        if (done && byte_state && !ack_seen)
            rsp_nack <= 1'b1;  // sticky until next request
        if (done && state == S_DATA_RD)
            rsp_rdata <= rx_byte;
        if (launch)
        begin
            cmd_op   <= op_for(state_n);
            cmd_byte <= byte_for(state_n, addr_r, wdata_r);
        end
    end

    a_rsp_hold: assert property (@(posedge CLK) disable iff (RESET)
        (rsp_valid && !rsp_ready) |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_nack));

    a_no_cmd_idle: assert property (@(posedge CLK) disable iff (RESET)
        (state == S_IDLE) |-> !cmd_valid);

endmodule

`default_nettype wire

/* eeprom_if_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_if_top
    import eeprom_pkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET,
    input  wire logic              req_valid,
    output wire logic              req_ready,
    input  wire logic              req_write,
    input  wire logic [ADDR_W-1:0] req_addr,
    input  wire logic [DATA_W-1:0] req_wdata,
    output wire logic              rsp_valid,
    input  wire logic              rsp_ready,
    output wire logic [DATA_W-1:0] rsp_rdata,
    output wire logic              rsp_nack,
    output wire logic              scl,
    output wire logic              sda_drive_low,  // open drain, 1 pulls low
    input  wire logic              sda_in
);

    wire logic              cmd_valid;
    wire logic              cmd_ready;
    wire bit_cmd_e          cmd_op;
    wire logic [DATA_W-1:0] cmd_byte;
    wire logic              done;
    wire logic [DATA_W-1:0] rx_byte;
    wire logic              ack_seen;

    eeprom_ctrl ctrl_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_byte  (cmd_byte),
        .cmd_ready (cmd_ready),
        .done      (done),
        .rx_byte   (rx_byte),
        .ack_seen  (ack_seen)
    );

    i2c_bit_engine engine_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_byte      (cmd_byte),
        .sda_in        (sda_in),
        .cmd_ready     (cmd_ready),
        .done          (done),
        .rx_byte       (rx_byte),
        .ack_seen      (ack_seen),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

endmodule

`default_nettype wire

/* tb_eeprom_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_model
    import eeprom_pkg::*;
(
    input  wire logic         CLK,
    input  wire logic         RESET,
    input  wire logic         scl,
    input  wire logic         sda,
    input  wire logic         force_nack,  // leave every ack bit released
    output logic              sda_drive_low,
    output logic              proto_err,
    output logic              busy,
    output logic [DATA_W-1:0] last_ctrl
);

    typedef enum logic [2:0] {
        P_IGNORE,
        P_CTRL,
        P_ADDR,
        P_DATA,
        P_RDACK,  // read control byte acked, data goes out next
        P_SEND
    } phase_e;

    logic [DATA_W-1:0] mem [0:2**ADDR_W-1];
    phase_e            phase;
    logic [ADDR_W-1:0] ptr;
    logic [2:0]        block;
    logic [3:0]        slot;  // scl rises seen in the current byte
    logic [DATA_W-1:0] sreg;
    logic [DATA_W-1:0] txreg;
    logic              scl_q;
    logic              sda_q;

    initial
    begin
        for (int i = 0; i < 2**ADDR_W; i++)
            mem[i] = 8'(i ^ (i >> 5));  // every address bit shows in the data
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
            slot          <= '0;
            phase         <= P_IGNORE;
            ptr           <= '0;
            busy          <= 1'b0;
            proto_err     <= 1'b0;
            sda_drive_low <= 1'b0;
            last_ctrl     <= '0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && (sda != sda_q))
            begin
                // start or stop, only legal right after a byte boundary
                if (slot != 4'd1)
                begin
                    proto_err <= 1'b1;
                    $display("model: sda moved under high scl inside a byte at %0t", $time);
                end
                slot          <= '0;
                sda_drive_low <= 1'b0;
                busy          <= !sda;
                phase         <= sda ? P_IGNORE : P_CTRL;
            end
            else if (scl && !scl_q)
            begin
                if (slot < 4'd8)
                    sreg <= {sreg[DATA_W-2:0], sda};
                else if (phase == P_SEND && sda)
                    phase <= P_IGNORE;  // master nack ends the read
                slot <= slot + 1'b1;
            end
            else if (!scl && scl_q)
            begin
                if (slot == 4'd8)
                begin
                    sda_drive_low <= 1'b0;
                    if (phase == P_CTRL || phase == P_ADDR || phase == P_DATA)
                    begin
                        if (force_nack || (phase == P_CTRL && sreg[7:4] != 4'b1010))
                            phase <= P_IGNORE;
                        else
                        begin
                            sda_drive_low <= 1'b1;
                            case (phase)
                                P_CTRL:
                                begin
                                    last_ctrl <= sreg;
                                    block     <= sreg[3:1];
                                    phase     <= sreg[0] ? P_RDACK : P_ADDR;
                                end
                                P_ADDR:
                                begin
                                    ptr   <= {block, sreg};
                                    phase <= P_DATA;
                                end
                                default:
                                begin
                                    mem[ptr] <= sreg;
                                    ptr      <= ptr + 1'b1;
                                end
                            endcase
                        end
                    end
                end
                else if (slot == 4'd9)
                begin
                    slot          <= '0;
                    sda_drive_low <= 1'b0;
                    if (phase == P_RDACK || phase == P_SEND)
                    begin
                        phase         <= P_SEND;
                        txreg         <= mem[ptr];
                        sda_drive_low <= !mem[ptr][DATA_W-1];  // msb first
                        ptr           <= ptr + 1'b1;
                    end
                end
                else if (phase == P_SEND && slot != 4'd0)
                    sda_drive_low <= !txreg[DATA_W-1-slot];
            end
        end
    end

endmodule

`default_nettype wire

/* tb_eeprom_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_top
    import eeprom_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int N_RANDOM    = 200;
    localparam int N_REQ       = N_RANDOM + 4;
    localparam int WATCHDOG_NS = N_REQ * 7 * 36 * SCL_QUARTER * CLK_PERIOD * 2;

    logic              CLK;
    logic              RESET;
    logic              req_valid;
    logic              req_ready;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [DATA_W-1:0] rsp_rdata;
    logic              rsp_nack;
    logic              scl;
    logic              dut_sda_low;
    logic              model_sda_low;
    logic              sda_bus;
    logic              force_nack;
    logic              model_err;
    logic              model_busy;
    logic [DATA_W-1:0] last_ctrl;

    logic [DATA_W-1:0] shadow [0:2**ADDR_W-1];
    logic [DATA_W+1:0] exp_q [$];  // {is_read, nack, rdata}
    logic [15:0]       lfsr_state = 16'd60;
    int                rsp_count  = 0;

    assign sda_bus = !(dut_sda_low || model_sda_low);  // open drain

    eeprom_if_top eeprom_if_top_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_rdata     (rsp_rdata),
        .rsp_nack      (rsp_nack),
        .scl           (scl),
        .sda_drive_low (dut_sda_low),
        .sda_in        (sda_bus)
    );

    tb_eeprom_model model_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda_bus),
        .force_nack    (force_nack),
        .sda_drive_low (model_sda_low),
        .proto_err     (model_err),
        .busy          (model_busy),
        .last_ctrl     (last_ctrl)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // a random read returns whatever was last written there
    function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
        return shadow[addr];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want)
        begin
            $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, want);
            abort_run("value check failed");
        end
    endtask

    task automatic do_request(
        input logic              wr,
        input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] data,
        input int                hold
    );
        logic [DATA_W-1:0] held_rdata;
        logic              held_nack;
        exp_q.push_back({!wr, force_nack, ref_read(addr)});
        if (wr && !force_nack)
            shadow[addr] = data;  // a nacked write never reaches the array
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = data;
        @(posedge CLK);
        while (!req_ready)
            @(posedge CLK);
        #1 req_valid = 1'b0;
        @(posedge CLK);
        while (!rsp_valid)
            @(posedge CLK);
        held_rdata = rsp_rdata;
        held_nack  = rsp_nack;
        repeat (hold)
        begin
            @(posedge CLK);
            check_equal(rsp_valid, 1, "rsp_valid under back-pressure");
            check_equal(rsp_rdata, held_rdata, "rsp_rdata under back-pressure");
            check_equal(rsp_nack, held_nack, "rsp_nack under back-pressure");
            check_equal(req_ready, 0, "req_ready while response pending");
            check_equal(scl, 1, "scl idle while response pending");
            check_equal(dut_sda_low, 0, "sda released while response pending");
        end
        #1 rsp_ready = 1'b1;
        @(posedge CLK);
        #1 rsp_ready = 1'b0;
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial
    begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired, the DUT stopped answering requests");
    end

    initial
    begin : response_check
        logic [DATA_W+1:0] exp_word;
        forever
        begin
            @(posedge CLK);
            if (!RESET && model_err)
                abort_run("EEPROM model saw a bus protocol error");
            else if (!RESET && rsp_valid && rsp_ready)
            begin
                if (exp_q.size() == 0)
                    abort_run("response arrived with no request outstanding");
                else
                begin
                    exp_word = exp_q.pop_front();
                    check_equal(rsp_nack, exp_word[DATA_W], "rsp_nack");
                    if (exp_word[DATA_W+1])
                        check_equal(rsp_rdata, exp_word[DATA_W-1:0], "read data");
                    check_equal(model_busy, 0, "transfer closed by a stop");
                    rsp_count++;
                end
            end
        end
    end

    initial
    begin : stimulus
        logic [31:0] bits;
        logic        wr;
        logic [10:0] addr;
        logic [7:0]  data;
        int          hold;

        RESET      = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        rsp_ready  = 1'b0;
        force_nack = 1'b0;
        for (int i = 0; i < 2**ADDR_W; i++)
            shadow[i] = 8'(i ^ (i >> 5));  // same preset as the model
        repeat (10) @(posedge CLK);
        #1 RESET = 1'b0;

        @(posedge CLK);
        check_equal(scl, 1, "scl after reset");
        check_equal(dut_sda_low, 0, "sda_drive_low after reset");
        check_equal(req_ready, 1, "req_ready after reset");
        check_equal(rsp_valid, 0, "rsp_valid after reset");
        #1;

        // 0x5A3 puts block 101 in the control byte
        do_request(1'b1, 11'h5A3, 8'hC7, 0);
        check_equal(last_ctrl, 8'hAA, "write control byte");
        do_request(1'b0, 11'h5A3, 8'h00, 3);
        check_equal(last_ctrl, 8'hAB, "read control byte");

        for (int i = 0; i < N_RANDOM; i++)
        begin
            bits = take_bits(1);
            wr   = bits[0];
            bits = take_bits(ADDR_W);
            addr = bits[10:0];
            bits = take_bits(DATA_W);
            data = bits[7:0];
            bits = take_bits(6);
            hold = bits[5:0];
            do_request(wr, addr, data, hold);
        end

        force_nack = 1'b1;
        do_request(1'b1, 11'h5A3, 8'h3C, 5);
        force_nack = 1'b0;
        do_request(1'b0, 11'h5A3, 8'h00, 0);

        #(CLK_PERIOD * 20);
        if (rsp_count == N_REQ && exp_q.size() == 0 && !model_err && !model_busy)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
            abort_run("run ended with missing responses or an open bus transfer");
    end

endmodule

`default_nettype wire

/* vlog.f */
eeprom_pkg.sv
i2c_bit_engine.sv
eeprom_ctrl.sv
eeprom_if_top.sv
tb_eeprom_model.sv
tb_eeprom_top.sv
